//--- hw/vcfg_pkg.sv
`default_nettype none

package vcfg_pkg;

    // vector register geometry
    localparam int unsigned VLEN         = 512;
    localparam int unsigned VMAXELEM_LOG = 6;     // 512 / 8 = 64 elements

    // speculative configuration queue
    localparam int unsigned VCFG_QUEUE_DEPTH = 4;
    localparam int unsigned VCFG_IDX_W       = 2;
    localparam int unsigned VCFG_CNT_W       = VCFG_IDX_W + 1;  // holds 0..depth

    // vector length, wide enough to hold VLMAX itself
    typedef logic [VMAXELEM_LOG:0] vl_t;

    // avl operand from the scalar register file
    typedef logic [63:0] avl_t;

    // raw vtype field
    // [2:0] vlmul, [5:3] vsew, [6] vta, [7] vma, [10:8] reserved
    typedef logic [10:0] vtype_t;

    // queue entry index and occupancy
    typedef logic [VCFG_IDX_W-1:0] cfg_idx_t;
    typedef logic [VCFG_CNT_W-1:0] cfg_cnt_t;

    // how the avl operand is interpreted
    typedef enum logic [1:0] {
        AVL_REG  = 2'd0,   // use the register value
        AVL_MAX  = 2'd1,   // rs1 = x0, rd != x0
        AVL_KEEP = 2'd2    // rs1 = x0, rd = x0
    } avl_mode_e;

endpackage

`default_nettype wire

//--- hw/vlmax_calc.sv
`default_nettype none

module vlmax_calc (
    input  vcfg_pkg::vtype_t vtype_i,
    output vcfg_pkg::vl_t    vlmax_o,
    output logic [2:0]       sew_o
);

    import vcfg_pkg::*;

    localparam vl_t ELEM_BASE = vl_t'(VLEN / 8);  // element count at sew 8, lmul 1

    logic [2:0] vsew;
    logic [2:0] vlmul;
    vl_t        sew_scaled;

    assign vsew  = vtype_i[5:3];
    assign vlmul = vtype_i[2:0];

    // vsew is already log2(sew / 8)
    assign sew_o = vsew;

    assign sew_scaled = ELEM_BASE >> vsew;

    always_comb begin
        case (vlmul)
            3'b101:  vlmax_o = sew_scaled >> 3;  // lmul 1/8
            3'b110:  vlmax_o = sew_scaled >> 2;  // lmul 1/4
            3'b111:  vlmax_o = sew_scaled >> 1;  // lmul 1/2
            default: vlmax_o = sew_scaled;       // lmul 1, larger ones are illegal
        endcase
    end

endmodule

`default_nettype wire

//--- hw/vl_grant.sv
`default_nettype none

module vl_grant (
    input  vcfg_pkg::vtype_t    vtype_i,
    input  vcfg_pkg::avl_t      avl_i,
    input  vcfg_pkg::avl_mode_e avl_mode_i,
    input  vcfg_pkg::vl_t       vlmax_i,
    input  vcfg_pkg::vl_t       cur_vl_i,
    output vcfg_pkg::vl_t       vl_o,
    output logic                vill_o,
    output logic                narrow_wide_o
);

    import vcfg_pkg::*;

    logic [2:0] vlmul;
    logic [2:0] vsew;
    logic       vta;
    logic [2:0] reserved;

    avl_t vlmax_ext;
    avl_t vlmax_dbl;
    avl_t avl_half_up;
    vl_t  vl_req;

    assign vlmul    = vtype_i[2:0];
    assign vsew     = vtype_i[5:3];
    assign vta      = vtype_i[6];
    assign reserved = vtype_i[10:8];

    assign vlmax_ext   = avl_t'(vlmax_i);
    assign vlmax_dbl   = vlmax_ext << 1;
    assign avl_half_up = (avl_i >> 1) + avl_t'(avl_i[0]);  // ceil(avl / 2)

    // requested length before the legality check
    always_comb begin
        case (avl_mode_i)
            AVL_MAX:  vl_req = vlmax_i;
            AVL_KEEP: vl_req = cur_vl_i;
            default: begin
                if (avl_i <= vlmax_ext) begin
                    vl_req = vl_t'(avl_i);
                end else if (avl_i <= vlmax_dbl) begin
                    vl_req = vl_t'(avl_half_up);  // split evenly over two strips
                end else begin
                    vl_req = vlmax_i;
                end
            end
        endcase
    end

    // unsupported tail policy or sew/lmul pair
    always_comb begin
        vill_o = 1'b0;
        if (reserved != 3'b000) begin
            vill_o = 1'b1;
        end
        if (!vta) begin
            vill_o = 1'b1;   // only tail agnostic is supported
        end
        if (vsew > 3'd3) begin
            vill_o = 1'b1;
        end
        if ((vlmul != 3'b000) && (vlmul <= 3'd4)) begin
            vill_o = 1'b1;   // integer lmul > 1 or reserved encoding
        end
        if (vlmul[2] && (vlmul[1:0] != 2'b00) && ({1'b0, vlmul[1:0]} <= vsew)) begin
            vill_o = 1'b1;   // fraction too small for this sew
        end
    end

    assign vl_o = vill_o ? '0 : vl_req;

    assign narrow_wide_o = vlmul[2] || (vl_o <= (vlmax_i >> 1));

endmodule

`default_nettype wire

//--- hw/vcfg_queue_store.sv
`default_nettype none

module vcfg_queue_store (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               wr_en_i,
    input  vcfg_pkg::cfg_idx_t wr_idx_i,
    input  vcfg_pkg::vl_t      wr_vl_i,
    input  vcfg_pkg::vl_t      wr_vlmax_i,
    input  vcfg_pkg::vtype_t   wr_vtype_i,
    input  logic               wr_vill_i,
    input  logic               wr_nw_i,
    input  logic               commit_en_i,
    input  vcfg_pkg::cfg_idx_t commit_idx_i,
    input  logic               restore_committed_i,
    input  vcfg_pkg::cfg_idx_t rd_idx_i,
    output vcfg_pkg::vl_t      cur_vl_o,
    output vcfg_pkg::vl_t      cur_vlmax_o,
    output vcfg_pkg::vtype_t   cur_vtype_o,
    output logic               cur_vill_o,
    output logic               cur_nw_o,
    output vcfg_pkg::vl_t      committed_vl_o,
    output logic               committed_vill_o
);

    import vcfg_pkg::*;

    // speculative entries
    vl_t    entry_vl    [VCFG_QUEUE_DEPTH];
    vl_t    entry_vlmax [VCFG_QUEUE_DEPTH];
    vtype_t entry_vtype [VCFG_QUEUE_DEPTH];
    logic   entry_vill  [VCFG_QUEUE_DEPTH];
    logic   entry_nw    [VCFG_QUEUE_DEPTH];

    // architectural copy
    vl_t    cmt_vl;
    vl_t    cmt_vlmax;
    vtype_t cmt_vtype;
    logic   cmt_vill;
    logic   cmt_nw;

    logic   sel_committed;  // current view comes from the committed copy

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            entry_vl[wr_idx_i]    <= wr_vl_i;
            entry_vlmax[wr_idx_i] <= wr_vlmax_i;
            entry_vtype[wr_idx_i] <= wr_vtype_i;
            entry_vill[wr_idx_i]  <= wr_vill_i;
            entry_nw[wr_idx_i]    <= wr_nw_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmt_vl        <= '0;
            cmt_vlmax     <= '0;
            cmt_vtype     <= '0;
            cmt_vill      <= 1'b1;   // no legal config until the first vset retires
            cmt_nw        <= 1'b0;
            sel_committed <= 1'b1;
        end else begin
            if (commit_en_i) begin
                cmt_vl    <= entry_vl[commit_idx_i];    // head moves to arch state
                cmt_vlmax <= entry_vlmax[commit_idx_i];
                cmt_vtype <= entry_vtype[commit_idx_i];
                cmt_vill  <= entry_vill[commit_idx_i];
                cmt_nw    <= entry_nw[commit_idx_i];
            end
            if (restore_committed_i) begin
                sel_committed <= 1'b1;
            end else if (wr_en_i) begin
                sel_committed <= 1'b0;   // youngest entry is valid again
            end
        end
    end

    assign cur_vl_o    = sel_committed ? cmt_vl    : entry_vl[rd_idx_i];
    assign cur_vlmax_o = sel_committed ? cmt_vlmax : entry_vlmax[rd_idx_i];
    assign cur_vtype_o = sel_committed ? cmt_vtype : entry_vtype[rd_idx_i];
    assign cur_vill_o  = sel_committed ? cmt_vill  : entry_vill[rd_idx_i];
    assign cur_nw_o    = sel_committed ? cmt_nw    : entry_nw[rd_idx_i];

    assign committed_vl_o   = cmt_vl;
    assign committed_vill_o = cmt_vill;

endmodule

`default_nettype wire

//--- hw/vcfg_ctrl.sv
`default_nettype none

module vcfg_ctrl (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               vset_valid_i,
    input  logic               commit_i,
    input  logic               recover_commit_i,
    input  logic               recover_mispredict_i,
    input  vcfg_pkg::cfg_idx_t mispredict_idx_i,
    output logic               wr_en_o,
    output vcfg_pkg::cfg_idx_t wr_idx_o,
    output logic               commit_en_o,
    output vcfg_pkg::cfg_idx_t commit_idx_o,
    output vcfg_pkg::cfg_idx_t rd_idx_o,
    output logic               restore_committed_o,
    output logic               full_o
);

    import vcfg_pkg::*;

    localparam cfg_cnt_t CNT_FULL = cfg_cnt_t'(VCFG_QUEUE_DEPTH);

    cfg_idx_t head;
    cfg_idx_t tail;
    cfg_cnt_t count;

    logic     any_recover;
    logic     empty;
    cfg_idx_t mp_span;      // entries from head up to the mispredict index, minus one
    cfg_cnt_t cnt_inc;
    cfg_cnt_t cnt_dec;

    assign any_recover = recover_commit_i || recover_mispredict_i;
    assign empty       = (count == '0);
    assign full_o      = (count == CNT_FULL);

    // recoveries win over regular traffic
    assign wr_en_o     = vset_valid_i && !full_o && !any_recover;  // dropped when full
    assign commit_en_o = commit_i && !empty && !any_recover;

    assign restore_committed_o = recover_commit_i;

    assign wr_idx_o     = tail;
    assign commit_idx_o = head;
    assign rd_idx_o     = tail - cfg_idx_t'(1);   // last written entry

    assign mp_span = mispredict_idx_i - head;
    assign cnt_inc = cfg_cnt_t'(wr_en_o);
    assign cnt_dec = cfg_cnt_t'(commit_en_o);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (recover_commit_i) begin
            head  <= tail;   // drop all speculative entries
            count <= '0;
        end else if (recover_mispredict_i) begin
            tail  <= mispredict_idx_i + cfg_idx_t'(1);
            count <= cfg_cnt_t'(mp_span) + cfg_cnt_t'(1);
        end else begin
            if (wr_en_o) begin
                tail <= tail + cfg_idx_t'(1);
            end
            if (commit_en_o) begin
                head <= head + cfg_idx_t'(1);
            end
            count <= count + cnt_inc - cnt_dec;  // write and commit may pair up
        end
    end

endmodule

`default_nettype wire

//--- hw/vcfg_unit.sv
`default_nettype none

module vcfg_unit (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                vset_valid_i,
    input  vcfg_pkg::vtype_t    vtype_i,
    input  vcfg_pkg::avl_t      avl_i,
    input  vcfg_pkg::avl_mode_e avl_mode_i,
    input  logic                commit_i,
    input  logic                recover_commit_i,
    input  logic                recover_mispredict_i,
    input  vcfg_pkg::cfg_idx_t  mispredict_idx_i,
    output vcfg_pkg::vl_t       vl_o,
    output vcfg_pkg::vl_t       vlmax_o,
    output logic                vill_o,
    output logic [2:0]          sew_o,
    output logic [2:0]          vlmul_o,
    output logic                vma_o,
    output logic                vta_o,
    output logic                narrow_wide_o,
    output vcfg_pkg::vl_t       committed_vl_o,
    output logic                committed_vill_o,
    output vcfg_pkg::cfg_idx_t  vset_idx_o,
    output logic                full_o
);

    import vcfg_pkg::*;

    vl_t      new_vlmax;
    vl_t      new_vl;
    logic     new_vill;
    logic     new_nw;
    logic [2:0] new_sew;
    vtype_t   new_vtype;

    logic     wr_en;
    cfg_idx_t wr_idx;
    logic     commit_en;
    cfg_idx_t commit_idx;
    cfg_idx_t rd_idx;
    logic     restore_committed;

    vtype_t   cur_vtype;

    vlmax_calc vlmax_calc_i (
        .vtype_i (vtype_i),
        .vlmax_o (new_vlmax),
        .sew_o   (new_sew)
    );

    vl_grant vl_grant_i (
        .vtype_i       (vtype_i),
        .avl_i         (avl_i),
        .avl_mode_i    (avl_mode_i),
        .vlmax_i       (new_vlmax),
        .cur_vl_i      (vl_o),
        .vl_o          (new_vl),
        .vill_o        (new_vill),
        .narrow_wide_o (new_nw)
    );

    // an illegal vtype is stored cleared, only vill survives
    assign new_vtype = new_vill ? '0 : {vtype_i[10:6], new_sew, vtype_i[2:0]};

    vcfg_ctrl vcfg_ctrl_i (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .vset_valid_i         (vset_valid_i),
        .commit_i             (commit_i),
        .recover_commit_i     (recover_commit_i),
        .recover_mispredict_i (recover_mispredict_i),
        .mispredict_idx_i     (mispredict_idx_i),
        .wr_en_o              (wr_en),
        .wr_idx_o             (wr_idx),
        .commit_en_o          (commit_en),
        .commit_idx_o         (commit_idx),
        .rd_idx_o             (rd_idx),
        .restore_committed_o  (restore_committed),
        .full_o               (full_o)
    );

    vcfg_queue_store vcfg_queue_store_i (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .wr_en_i             (wr_en),
        .wr_idx_i            (wr_idx),
        .wr_vl_i             (new_vl),
        .wr_vlmax_i          (new_vlmax),
        .wr_vtype_i          (new_vtype),
        .wr_vill_i           (new_vill),
        .wr_nw_i             (new_nw),
        .commit_en_i         (commit_en),
        .commit_idx_i        (commit_idx),
        .restore_committed_i (restore_committed),
        .rd_idx_i            (rd_idx),
        .cur_vl_o            (vl_o),
        .cur_vlmax_o         (vlmax_o),
        .cur_vtype_o         (cur_vtype),
        .cur_vill_o          (vill_o),
        .cur_nw_o            (narrow_wide_o),
        .committed_vl_o      (committed_vl_o),
        .committed_vill_o    (committed_vill_o)
    );

    assign vset_idx_o = wr_idx;   // slot the next vset lands in

    assign vlmul_o = cur_vtype[2:0];
    assign sew_o   = cur_vtype[5:3];
    assign vta_o   = cur_vtype[6];
    assign vma_o   = cur_vtype[7];

endmodule

`default_nettype wire

//--- dv/vcfg_unit_tb.sv
`default_nettype none

module vcfg_unit_tb;

    import vcfg_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_OPS     = 200;
    localparam int MAX_ROWS     = 300;
    localparam int SEED         = 43;
    localparam int WD_MARGIN    = 50;   // spare cycles for the watchdog
    localparam int DEPTH        = int'(VCFG_QUEUE_DEPTH);

    localparam int OP_IDLE       = 0;
    localparam int OP_VSET       = 1;
    localparam int OP_COMMIT     = 2;
    localparam int OP_RECOVER    = 3;
    localparam int OP_MISPREDICT = 4;

    typedef struct packed {
        int        op;
        vtype_t    vtype;
        avl_t      avl;
        avl_mode_e mode;
        cfg_idx_t  mp_idx;
        vl_t       exp_vl;
        vl_t       exp_vlmax;
        vtype_t    exp_vtype;
        logic      exp_vill;
        logic      exp_nw;
        logic      exp_full;
        cfg_idx_t  exp_idx;
        vl_t       exp_cvl;
        logic      exp_cvill;
    } row_t;

    logic      clk;
    logic      rst;
    logic      vset_valid;
    vtype_t    vtype;
    avl_t      avl;
    avl_mode_e avl_mode;
    logic      commit;
    logic      recover_commit;
    logic      recover_mispredict;
    cfg_idx_t  mispredict_idx;
    vl_t       vl;
    vl_t       vlmax;
    logic      vill;
    logic [2:0] sew;
    logic [2:0] vlmul;
    logic      vma;
    logic      vta;
    logic      narrow_wide;
    vl_t       committed_vl;
    logic      committed_vill;
    cfg_idx_t  vset_idx;
    logic      full;

    row_t rows [MAX_ROWS];
    int   num_rows;
    int   err_count;
    int   check_count;
    int   rng_init;
    logic table_ready;

    // queue mirror of the reference model
    vl_t      m_vl    [DEPTH];
    vl_t      m_vlmax [DEPTH];
    vtype_t   m_vtype [DEPTH];
    logic     m_vill  [DEPTH];
    logic     m_nw    [DEPTH];
    vl_t      m_cvl;
    vl_t      m_cvlmax;
    vtype_t   m_cvtype;
    logic     m_cvill;
    logic     m_cnw;
    cfg_idx_t m_head;
    cfg_idx_t m_tail;
    int       m_count;
    logic     m_sel_cmt;   // current view shows the committed copy

    int lmul_pool [7] = '{0, 0, 5, 6, 7, 2, 4};  // weighted toward legal lmul

    vcfg_unit vcfg_unit_i (
        .clk_i                (clk),
        .rst_i                (rst),
        .vset_valid_i         (vset_valid),
        .vtype_i              (vtype),
        .avl_i                (avl),
        .avl_mode_i           (avl_mode),
        .commit_i             (commit),
        .recover_commit_i     (recover_commit),
        .recover_mispredict_i (recover_mispredict),
        .mispredict_idx_i     (mispredict_idx),
        .vl_o                 (vl),
        .vlmax_o              (vlmax),
        .vill_o               (vill),
        .sew_o                (sew),
        .vlmul_o              (vlmul),
        .vma_o                (vma),
        .vta_o                (vta),
        .narrow_wide_o        (narrow_wide),
        .committed_vl_o       (committed_vl),
        .committed_vill_o     (committed_vill),
        .vset_idx_o           (vset_idx),
        .full_o               (full)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic vtype_t make_vtype(int sew_v, int lmul_v, bit ta, bit ma, int rsv);
        return {3'(rsv), ma, ta, 3'(sew_v), 3'(lmul_v)};
    endfunction

    function automatic vtype_t vtype_of(int sew_v, int lmul_v);
        return make_vtype(sew_v, lmul_v, 1'b1, 1'b0, 0);  // tail agnostic, no reserved bits
    endfunction

    function automatic int ref_vlmax(vtype_t vt);
        int elems;
        int lmul_v;
        elems  = int'(VLEN / 8) >> vt[5:3];
        lmul_v = int'(vt[2:0]);
        if (lmul_v >= 5) begin
            elems = elems >> (8 - lmul_v);   // 1/8, 1/4, 1/2
        end
        return elems;
    endfunction

    function automatic logic ref_vill(vtype_t vt);
        int lmul_v;
        int sew_v;
        lmul_v = int'(vt[2:0]);
        sew_v  = int'(vt[5:3]);
        return (vt[10:8] != 3'b000) || !vt[6] || (sew_v > 3) ||
               (lmul_v >= 1 && lmul_v <= 4) || (lmul_v >= 5 && (lmul_v % 4) <= sew_v);
    endfunction

    function automatic int ref_vl(vtype_t vt, avl_t avl_v, avl_mode_e mode, int cur_vl);
        avl_t lim;
        lim = avl_t'(ref_vlmax(vt));
        if (ref_vill(vt)) begin
            return 0;
        end
        if (mode == AVL_MAX) begin
            return int'(lim);
        end
        if (mode == AVL_KEEP) begin
            return cur_vl;
        end
        if (avl_v <= lim) begin
            return int'(avl_v);
        end else if (avl_v <= (lim << 1)) begin
            return int'((avl_v + 64'd1) >> 1);   // two even strips
        end
        return int'(lim);
    endfunction

    function automatic logic ref_nw(vtype_t vt, int vl_v);
        return vt[2] || (vl_v <= ref_vlmax(vt) / 2);
    endfunction

    task automatic reset_model();
        for (int k = 0; k < DEPTH; k++) begin
            m_vl[k]    = '0;
            m_vlmax[k] = '0;
            m_vtype[k] = '0;
            m_vill[k]  = 1'b1;
            m_nw[k]    = 1'b0;
        end
        m_cvl     = '0;
        m_cvlmax  = '0;
        m_cvtype  = '0;
        m_cvill   = 1'b1;
        m_cnw     = 1'b0;
        m_head    = '0;
        m_tail    = '0;
        m_count   = 0;
        m_sel_cmt = 1'b1;
    endtask

    task automatic model_vset(input vtype_t vt, input avl_t avl_v, input avl_mode_e mode);
        cfg_idx_t last;
        vl_t      cur;
        int       vl_v;
        if (m_count == DEPTH) begin
            return;   // dropped while full
        end
        last = m_tail - cfg_idx_t'(1);
        cur  = m_sel_cmt ? m_cvl : m_vl[last];
        vl_v = ref_vl(vt, avl_v, mode, int'(cur));
        m_vl[m_tail]    = vl_t'(vl_v);
        m_vlmax[m_tail] = vl_t'(ref_vlmax(vt));
        m_vtype[m_tail] = ref_vill(vt) ? '0 : vt;   // vill leaves the other fields zero
        m_vill[m_tail]  = ref_vill(vt);
        m_nw[m_tail]    = ref_nw(vt, vl_v);
        m_tail    = m_tail + cfg_idx_t'(1);
        m_count   = m_count + 1;
        m_sel_cmt = 1'b0;
    endtask

    task automatic model_step(input int op, input vtype_t vt, input avl_t avl_v,
                              input avl_mode_e mode, input cfg_idx_t idx);
        cfg_idx_t span;
        if (op == OP_VSET) begin
            model_vset(vt, avl_v, mode);
        end else if (op == OP_COMMIT && m_count > 0) begin
            m_cvl    = m_vl[m_head];   // oldest entry retires
            m_cvlmax = m_vlmax[m_head];
            m_cvtype = m_vtype[m_head];
            m_cvill  = m_vill[m_head];
            m_cnw    = m_nw[m_head];
            m_head   = m_head + cfg_idx_t'(1);
            m_count  = m_count - 1;
        end else if (op == OP_RECOVER) begin
            m_head    = m_tail;
            m_count   = 0;
            m_sel_cmt = 1'b1;
        end else if (op == OP_MISPREDICT) begin
            span    = idx - m_head;
            m_tail  = idx + cfg_idx_t'(1);
            m_count = int'(span) + 1;
        end
    endtask

    task automatic push_row(input int op, input vtype_t vt, input avl_t avl_v,
                            input avl_mode_e mode, input cfg_idx_t idx);
        row_t     r;
        cfg_idx_t last;
        r        = '0;
        r.op     = op;
        r.vtype  = vt;
        r.avl    = avl_v;
        r.mode   = mode;
        r.mp_idx = idx;
        model_step(op, vt, avl_v, mode, idx);
        last        = m_tail - cfg_idx_t'(1);
        r.exp_vl    = m_sel_cmt ? m_cvl : m_vl[last];
        r.exp_vlmax = m_sel_cmt ? m_cvlmax : m_vlmax[last];
        r.exp_vtype = m_sel_cmt ? m_cvtype : m_vtype[last];
        r.exp_vill  = m_sel_cmt ? m_cvill : m_vill[last];
        r.exp_nw    = m_sel_cmt ? m_cnw : m_nw[last];
        r.exp_full  = (m_count == DEPTH);
        r.exp_idx   = m_tail;
        r.exp_cvl   = m_cvl;
        r.exp_cvill = m_cvill;
        rows[num_rows] = r;
        num_rows = num_rows + 1;
    endtask

    task automatic push_op(input int op);
        push_row(op, '0, '0, AVL_REG, '0);
    endtask

    task automatic vset_commit(input vtype_t vt, input avl_t avl_v, input avl_mode_e mode);
        push_row(OP_VSET, vt, avl_v, mode, '0);
        push_op(OP_COMMIT);
    endtask

    task automatic build_table();
        int        pick;
        int        sel;
        vtype_t    vt;
        avl_mode_e mode;
        cfg_idx_t  idx;
        reset_model();
        num_rows = 0;
        push_op(OP_IDLE);                                              // reset values
        vset_commit(vtype_of(0, 0), 64'd10, AVL_REG);                   // e8 m1, vlmax 64
        vset_commit(vtype_of(0, 0), 64'd100, AVL_REG);                  // between 64 and 128
        vset_commit(vtype_of(0, 0), 64'd1000, AVL_REG);
        vset_commit(vtype_of(0, 0), '1, AVL_REG);
        vset_commit(vtype_of(2, 0), 64'd17, AVL_REG);                   // e32, vlmax 16
        vset_commit(vtype_of(2, 0), 64'd5, AVL_REG);
        vset_commit(vtype_of(0, 7), 64'd40, AVL_REG);                   // e8 mf2
        vset_commit(vtype_of(1, 6), 64'd0, AVL_MAX);                    // e16 mf4
        vset_commit(vtype_of(3, 0), 64'd0, AVL_MAX);
        vset_commit(vtype_of(3, 0), 64'd99, AVL_KEEP);
        vset_commit(vtype_of(2, 0), 64'd3, AVL_KEEP);
        vset_commit(make_vtype(0, 0, 1'b1, 1'b0, 1), 64'd8, AVL_REG);   // reserved bit
        vset_commit(make_vtype(0, 0, 1'b0, 1'b1, 0), 64'd8, AVL_REG);   // vta = 0
        vset_commit(vtype_of(0, 1), 64'd8, AVL_REG);                    // lmul 2
        vset_commit(vtype_of(0, 4), 64'd8, AVL_REG);                    // reserved lmul code
        vset_commit(vtype_of(3, 5), 64'd8, AVL_MAX);                    // e64 mf8
        vset_commit(vtype_of(2, 6), 64'd8, AVL_REG);                    // e32 mf4
        vset_commit(vtype_of(0, 0), 64'd5, AVL_KEEP);                   // keeps vl 0
        for (int k = 0; k < DEPTH; k++) begin
            push_row(OP_VSET, vtype_of(k, 0), 64'(k + 3), AVL_REG, '0);
        end
        push_row(OP_VSET, vtype_of(0, 0), 64'd50, AVL_REG, '0);         // full, dropped
        for (int k = 0; k < DEPTH; k++) begin
            push_op(OP_COMMIT);
        end
        push_row(OP_VSET, vtype_of(0, 0), 64'd7, AVL_REG, '0);
        push_row(OP_VSET, vtype_of(0, 0), 64'd9, AVL_REG, '0);
        push_row(OP_VSET, vtype_of(0, 0), 64'd11, AVL_REG, '0);
        push_row(OP_MISPREDICT, '0, '0, AVL_REG, m_head);               // back to oldest
        push_row(OP_VSET, vtype_of(0, 0), 64'd20, AVL_REG, '0);
        push_op(OP_COMMIT);
        push_row(OP_VSET, vtype_of(0, 0), 64'd30, AVL_REG, '0);
        push_op(OP_RECOVER);
        vset_commit(vtype_of(1, 0), 64'd1, AVL_KEEP);                   // restored vl kept
        for (int n = 0; n < RAND_OPS; n++) begin
            pick = int'($urandom_range(99));
            if (pick < 40) begin
                vt   = make_vtype(int'($urandom_range(4)), lmul_pool[$urandom_range(6)],
                                  ($urandom_range(9) != 0), 1'($urandom_range(1)),
                                  ($urandom_range(19) == 0) ? 2 : 0);
                sel  = int'($urandom_range(9));
                mode = (sel < 7) ? AVL_REG : ((sel < 9) ? AVL_MAX : AVL_KEEP);
                push_row(OP_VSET, vt, avl_t'($urandom_range(150)), mode, '0);
            end else if (pick < 65) begin
                push_op(OP_COMMIT);
            end else if (pick < 77 && m_count > 0) begin
                idx = m_head + cfg_idx_t'($urandom_range(m_count - 1));  // a live entry
                push_row(OP_MISPREDICT, '0, '0, AVL_REG, idx);
            end else if (pick >= 77 && pick < 82) begin
                push_op(OP_RECOVER);
            end else begin
                push_op(OP_IDLE);
            end
        end
    endtask

    task automatic clear_inputs();
        vset_valid         = 1'b0;
        vtype              = '0;
        avl                = '0;
        avl_mode           = AVL_REG;
        commit             = 1'b0;
        recover_commit     = 1'b0;
        recover_mispredict = 1'b0;
        mispredict_idx     = '0;
    endtask

    task automatic drive_row(input row_t r);
        clear_inputs();
        vset_valid         = (r.op == OP_VSET);
        vtype              = r.vtype;
        avl                = r.avl;
        avl_mode           = r.mode;
        commit             = (r.op == OP_COMMIT);
        recover_commit     = (r.op == OP_RECOVER);
        recover_mispredict = (r.op == OP_MISPREDICT);
        mispredict_idx     = r.mp_idx;
    endtask

    task automatic check_value(input int row, input string what,
                               input logic [63:0] actual, input logic [63:0] expected);
        check_count = check_count + 1;
        if (actual !== expected) begin
            err_count = err_count + 1;
            $display("Mismatch at time %0t: row %0d %s is %0h, expected %0h",
                     $time, row, what, actual, expected);
        end
    endtask

    task automatic check_row(input int i);
        check_value(i, "vl", 64'(vl), 64'(rows[i].exp_vl));
        check_value(i, "vlmax", 64'(vlmax), 64'(rows[i].exp_vlmax));
        check_value(i, "vill", 64'(vill), 64'(rows[i].exp_vill));
        check_value(i, "sew", 64'(sew), 64'(rows[i].exp_vtype[5:3]));
        check_value(i, "vlmul", 64'(vlmul), 64'(rows[i].exp_vtype[2:0]));
        check_value(i, "vta", 64'(vta), 64'(rows[i].exp_vtype[6]));
        check_value(i, "vma", 64'(vma), 64'(rows[i].exp_vtype[7]));
        check_value(i, "narrow_wide", 64'(narrow_wide), 64'(rows[i].exp_nw));
        check_value(i, "full", 64'(full), 64'(rows[i].exp_full));
        check_value(i, "vset_idx", 64'(vset_idx), 64'(rows[i].exp_idx));
        check_value(i, "committed_vl", 64'(committed_vl), 64'(rows[i].exp_cvl));
        check_value(i, "committed_vill", 64'(committed_vill), 64'(rows[i].exp_cvill));
    endtask

    initial begin : watchdog
        wait (table_ready);
        #((num_rows + RESET_CYCLES + WD_MARGIN) * CLK_PERIOD);
        $display("timeout: the stimulus loop did not finish in time");
        $display("test failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        table_ready = 1'b0;
        err_count   = 0;
        check_count = 0;
        clear_inputs();
        rng_init = int'($urandom(SEED));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // one row per cycle, results checked at the following falling edge
        for (int i = 0; i <= num_rows; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_row(i - 1);
            end
            if (i < num_rows) begin
                drive_row(rows[i]);
            end else begin
                clear_inputs();
            end
        end
        $display("rows: %0d, checks: %0d, errors: %0d", num_rows, check_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vcfg_unit.f
hw/vcfg_pkg.sv
hw/vlmax_calc.sv
hw/vl_grant.sv
hw/vcfg_queue_store.sv
hw/vcfg_ctrl.sv
hw/vcfg_unit.sv
dv/vcfg_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = vcfg_unit_tb
FILELIST  = vcfg_unit.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
